//--- free_list.sv
`include "rename_defines.svh"

module free_list (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic             [`RN_WAYS-1:0]       pop_en,
    input  logic             [`RN_WAYS-1:0]       push_valid,
    input  rename_pkg::prn_t [`RN_WAYS-1:0]       push_prn,
    input  logic                                  squash,
    input  logic             [`FL_PTR_WIDTH-1:0]  restore_head,
    output logic             [`RN_WAYS-1:0]       pop_valid,
    output rename_pkg::prn_t [`RN_WAYS-1:0]       pop_prn,
    output logic             [`FL_PTR_WIDTH-1:0]  head
);

    typedef logic [`FL_PTR_WIDTH-1:0] ptr_t;
    typedef logic [`FL_CTR_WIDTH-1:0] count_t;

    localparam count_t INIT_COUNT = count_t'(`PHYS_REG_SZ - `ARCH_REG_SZ);
    localparam count_t FULL_COUNT = count_t'(`PHYS_REG_SZ);
    localparam ptr_t   LAST_SLOT  = ptr_t'(`PHYS_REG_SZ - 1);

    rename_pkg::prn_t entries [`PHYS_REG_SZ];
    ptr_t             tail;
    count_t           count;

    ptr_t                  head_next;
    ptr_t                  tail_next;
    count_t                avail;
    count_t                count_next;
    ptr_t   [`RN_WAYS-1:0] push_slot;
    logic                  stall;

    // pops at the head in way order
    always_comb begin
        head_next = head;
        avail     = count;
        // no allocation while the queue is being reset or rewound
        stall     = squash || reset;
        for (int i = 0; i < `RN_WAYS; i++) begin
            pop_valid[i] = 1'b0;
            pop_prn[i]   = '0;
            if (pop_en[i] && !stall) begin
                if (avail != '0) begin
                    pop_valid[i] = 1'b1;
                    pop_prn[i]   = entries[head_next];
                    head_next    = (head_next == LAST_SLOT) ? '0 : head_next + 1'b1;
                    avail        = avail - 1'b1;
                end
            end
        end
    end

    // retire frees go in at the tail after the pops
    always_comb begin
        tail_next  = tail;
        count_next = avail;
        for (int i = 0; i < `RN_WAYS; i++) begin
            push_slot[i] = tail_next;
            if (push_valid[i]) begin
                tail_next  = (tail_next == LAST_SLOT) ? '0 : tail_next + 1'b1;
                count_next = count_next + 1'b1;
            end
        end
        // entries behind the retired head become free again
        if (squash) begin
            count_next = INIT_COUNT;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= ptr_t'(`ARCH_REG_SZ);
            tail  <= '0;
            count <= INIT_COUNT;
            for (int i = 0; i < `PHYS_REG_SZ; i++) begin
                entries[i] <= rename_pkg::prn_t'(i);
            end
        end else begin
            head  <= squash ? restore_head : head_next;
            tail  <= tail_next;
            count <= count_next;
            for (int i = 0; i < `RN_WAYS; i++) begin
                if (push_valid[i]) begin
                    entries[push_slot[i]] <= push_prn[i];
                end
            end
        end
    end

    // a freed register must have been handed out before
    push_not_full: assert property (@(posedge clock) disable iff (reset)
        |push_valid |-> avail < FULL_COUNT)
        else $error("free list push while full");

    count_in_range: assert property (@(posedge clock) disable iff (reset)
        count <= FULL_COUNT)
        else $error("free count above %0d", `PHYS_REG_SZ);

endmodule

//--- map_table.sv
`include "rename_defines.svh"

module map_table (
    input  logic                                  clock,
    input  logic                                  reset,
    input  rename_pkg::arn_t [`RN_WAYS-1:0]       src1_arch,
    input  rename_pkg::arn_t [`RN_WAYS-1:0]       src2_arch,
    input  rename_pkg::arn_t [`RN_WAYS-1:0]       dest_arch,
    input  logic             [`RN_WAYS-1:0]       alloc_valid,
    input  rename_pkg::prn_t [`RN_WAYS-1:0]       alloc_prn,
    input  logic                                  squash,
    input  rename_pkg::prn_t [`ARCH_REG_SZ-1:0]   retired_map,
    output rename_pkg::prn_t [`RN_WAYS-1:0]       src1_prn,
    output rename_pkg::prn_t [`RN_WAYS-1:0]       src2_prn,
    output rename_pkg::prn_t [`RN_WAYS-1:0]       old_prn
);

    // speculative arch to phys mapping
    rename_pkg::prn_t [`ARCH_REG_SZ-1:0] spec_map;

    always_comb begin
        for (int i = 0; i < `RN_WAYS; i++) begin
            src1_prn[i] = spec_map[src1_arch[i]];
            src2_prn[i] = spec_map[src2_arch[i]];
            old_prn[i]  = spec_map[dest_arch[i]];

            // same group forwarding, the youngest earlier writer wins
            for (int j = 0; j < i; j++) begin
                if (alloc_valid[j]) begin
                    if (dest_arch[j] == src1_arch[i]) begin
                        src1_prn[i] = alloc_prn[j];
                    end
                    if (dest_arch[j] == src2_arch[i]) begin
                        src2_prn[i] = alloc_prn[j];
                    end
                    if (dest_arch[j] == dest_arch[i]) begin
                        old_prn[i] = alloc_prn[j];
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REG_SZ; i++) begin
                spec_map[i] <= rename_pkg::prn_t'(i);
            end
        end else if (squash) begin
            // back to the committed state
            spec_map <= retired_map;
        end else begin
            // way order, so a later way to the same arch reg overrides
            for (int i = 0; i < `RN_WAYS; i++) begin
                if (alloc_valid[i]) begin
                    spec_map[dest_arch[i]] <= alloc_prn[i];
                end
            end
        end
    end

endmodule

//--- rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// instructions renamed per cycle
`define RN_WAYS 2

// architectural register file size
`define ARCH_REG_SZ 8

// physical register file size, must exceed ARCH_REG_SZ
`define PHYS_REG_SZ 16

// register index widths
`define ARN_WIDTH ($clog2(`ARCH_REG_SZ))
`define PRN_WIDTH ($clog2(`PHYS_REG_SZ))

// free list head and tail pointers
`define FL_PTR_WIDTH ($clog2(`PHYS_REG_SZ))

// free count needs to hold PHYS_REG_SZ itself
`define FL_CTR_WIDTH (`FL_PTR_WIDTH + 1)

`endif

//--- rename_pkg.sv
`include "rename_defines.svh"

package rename_pkg;

    // physical register number
    typedef logic [`PRN_WIDTH-1:0] prn_t;

    // architectural register number
    typedef logic [`ARN_WIDTH-1:0] arn_t;

endpackage

//--- rename_unit.sv
`include "rename_defines.svh"

module rename_unit (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic             [`RN_WAYS-1:0]       rename_valid,
    input  rename_pkg::arn_t [`RN_WAYS-1:0]       dest_arch,
    input  rename_pkg::arn_t [`RN_WAYS-1:0]       src1_arch,
    input  rename_pkg::arn_t [`RN_WAYS-1:0]       src2_arch,
    input  logic                                  squash,
    input  logic             [`RN_WAYS-1:0]       retire_valid,
    input  rename_pkg::arn_t [`RN_WAYS-1:0]       retire_arch,
    input  rename_pkg::prn_t [`RN_WAYS-1:0]       retire_prn,
    output logic             [`RN_WAYS-1:0]       rename_grant,
    output rename_pkg::prn_t [`RN_WAYS-1:0]       dest_prn,
    output rename_pkg::prn_t [`RN_WAYS-1:0]       old_prn,
    output rename_pkg::prn_t [`RN_WAYS-1:0]       src1_prn,
    output rename_pkg::prn_t [`RN_WAYS-1:0]       src2_prn
);

    logic             [`RN_WAYS-1:0]      freed_valid;
    rename_pkg::prn_t [`RN_WAYS-1:0]      freed_prn;
    rename_pkg::prn_t [`ARCH_REG_SZ-1:0]  retired_map;
    logic             [`FL_PTR_WIDTH-1:0] retired_head;

    // grants and new prns straight from the queue
    free_list free_list_inst (
        .clock        (clock),
        .reset        (reset),
        .pop_en       (rename_valid),
        .push_valid   (freed_valid),
        .push_prn     (freed_prn),
        .squash       (squash),
        .restore_head (retired_head),
        .pop_valid    (rename_grant),
        .pop_prn      (dest_prn),
        .head         ()
    );

    map_table map_table_inst (
        .clock        (clock),
        .reset        (reset),
        .src1_arch    (src1_arch),
        .src2_arch    (src2_arch),
        .dest_arch    (dest_arch),
        .alloc_valid  (rename_grant),
        .alloc_prn    (dest_prn),
        .squash       (squash),
        .retired_map  (retired_map),
        .src1_prn     (src1_prn),
        .src2_prn     (src2_prn),
        .old_prn      (old_prn)
    );

    retire_map retire_map_inst (
        .clock        (clock),
        .reset        (reset),
        .retire_valid (retire_valid),
        .retire_arch  (retire_arch),
        .retire_prn   (retire_prn),
        .squash       (squash),
        .freed_valid  (freed_valid),
        .freed_prn    (freed_prn),
        .retired_map  (retired_map),
        .retired_head (retired_head)
    );

endmodule

//--- retire_map.sv
`include "rename_defines.svh"

module retire_map (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic             [`RN_WAYS-1:0]       retire_valid,
    input  rename_pkg::arn_t [`RN_WAYS-1:0]       retire_arch,
    input  rename_pkg::prn_t [`RN_WAYS-1:0]       retire_prn,
    input  logic                                  squash,
    output logic             [`RN_WAYS-1:0]       freed_valid,
    output rename_pkg::prn_t [`RN_WAYS-1:0]       freed_prn,
    output rename_pkg::prn_t [`ARCH_REG_SZ-1:0]   retired_map,
    output logic             [`FL_PTR_WIDTH-1:0]  retired_head
);

    typedef logic [`FL_PTR_WIDTH-1:0] ptr_t;

    localparam ptr_t LAST_SLOT = ptr_t'(`PHYS_REG_SZ - 1);

    rename_pkg::prn_t [`ARCH_REG_SZ-1:0] commit_map;
    ptr_t                                head_next;

    assign retired_map = commit_map;
    assign freed_valid = retire_valid;

    // displaced committed mapping, chained within the group
    always_comb begin
        for (int i = 0; i < `RN_WAYS; i++) begin
            freed_prn[i] = commit_map[retire_arch[i]];
            for (int j = 0; j < i; j++) begin
                if (retire_valid[j] && retire_arch[j] == retire_arch[i]) begin
                    freed_prn[i] = retire_prn[j];
                end
            end
        end
    end

    // one popped free list entry per retiring way
    always_comb begin
        head_next = retired_head;
        for (int i = 0; i < `RN_WAYS; i++) begin
            if (retire_valid[i]) begin
                head_next = (head_next == LAST_SLOT) ? '0 : head_next + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            retired_head <= ptr_t'(`ARCH_REG_SZ);
            for (int i = 0; i < `ARCH_REG_SZ; i++) begin
                commit_map[i] <= rename_pkg::prn_t'(i);
            end
        end else begin
            retired_head <= head_next;
            for (int i = 0; i < `RN_WAYS; i++) begin
                if (retire_valid[i]) begin
                    commit_map[retire_arch[i]] <= retire_prn[i];
                end
            end
        end
    end

    // the ROB holds retire while the pipeline is flushed
    no_retire_on_squash: assert property (@(posedge clock) disable iff (reset)
        squash |-> retire_valid == '0)
        else $error("retire during squash");

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -j 0 --top-module tb_rename -f tb.f -o sim_rename \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_rename > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb.f
+incdir+.
rename_pkg.sv
free_list.sv
map_table.sv
retire_map.sv
rename_unit.sv
tb_rename.sv

//--- tb_rename.sv
`include "rename_defines.svh"

module tb_rename;

    typedef logic [`RN_WAYS-1:0] way_mask_t;

    localparam logic [31:0] SEED = 32'h5508_94f4;
    localparam int RESET_CYCLES   = 4;
    localparam int RANDOM_CYCLES  = 400;
    // directed tests 1 to 5 and the random mix
    localparam int TEST_CYCLES    = 2 + 3 + 2 + 10 + 7 + RANDOM_CYCLES;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;
    localparam int FREE_AT_RESET  = `PHYS_REG_SZ - `ARCH_REG_SZ;

    logic                            clock = 1'b0;
    logic                            reset = 1'b1;
    way_mask_t                       rename_valid;
    rename_pkg::arn_t [`RN_WAYS-1:0] dest_arch;
    rename_pkg::arn_t [`RN_WAYS-1:0] src1_arch;
    rename_pkg::arn_t [`RN_WAYS-1:0] src2_arch;
    logic                            squash;
    way_mask_t                       retire_valid;
    rename_pkg::arn_t [`RN_WAYS-1:0] retire_arch;
    rename_pkg::prn_t [`RN_WAYS-1:0] retire_prn;
    way_mask_t                       rename_grant;
    rename_pkg::prn_t [`RN_WAYS-1:0] dest_prn;
    rename_pkg::prn_t [`RN_WAYS-1:0] old_prn;
    rename_pkg::prn_t [`RN_WAYS-1:0] src1_prn;
    rename_pkg::prn_t [`RN_WAYS-1:0] src2_prn;

    // reference model state
    rename_pkg::prn_t spec_map   [`ARCH_REG_SZ];
    rename_pkg::prn_t commit_map [`ARCH_REG_SZ];
    rename_pkg::prn_t free_queue [`PHYS_REG_SZ];
    int               free_head;
    int               free_tail;
    int               free_count;
    int               commit_head;
    // renamed and not yet retired in program order
    rename_pkg::arn_t pend_arch [$];
    rename_pkg::prn_t pend_prn  [$];

    way_mask_t                       exp_grant;
    rename_pkg::prn_t [`RN_WAYS-1:0] exp_dest;
    rename_pkg::prn_t [`RN_WAYS-1:0] exp_old;
    rename_pkg::prn_t [`RN_WAYS-1:0] exp_src1;
    rename_pkg::prn_t [`RN_WAYS-1:0] exp_src2;

    int errors = 0;
    int checks = 0;
    int tests_done = 0;
    int test_start_errors = 0;
    int cycle_count = 0;

    rename_unit UUT (
        .clock        (clock),
        .reset        (reset),
        .rename_valid (rename_valid),
        .dest_arch    (dest_arch),
        .src1_arch    (src1_arch),
        .src2_arch    (src2_arch),
        .squash       (squash),
        .retire_valid (retire_valid),
        .retire_arch  (retire_arch),
        .retire_prn   (retire_prn),
        .rename_grant (rename_grant),
        .dest_prn     (dest_prn),
        .old_prn      (old_prn),
        .src1_prn     (src1_prn),
        .src2_prn     (src2_prn)
    );

    initial begin
        forever #2 clock = ~clock;
    end

    function automatic void reset_model();
        for (int i = 0; i < `ARCH_REG_SZ; i++) begin
            spec_map[i]   = rename_pkg::prn_t'(i);
            commit_map[i] = rename_pkg::prn_t'(i);
        end
        for (int i = 0; i < `PHYS_REG_SZ; i++) begin
            free_queue[i] = rename_pkg::prn_t'(i);
        end
        free_head   = `ARCH_REG_SZ;
        free_tail   = 0;
        free_count  = FREE_AT_RESET;
        commit_head = `ARCH_REG_SZ;
        pend_arch.delete();
        pend_prn.delete();
    endfunction

    // expected outputs for the applied inputs with ways taken one after another
    function automatic void compute_expected();
        rename_pkg::prn_t view [`ARCH_REG_SZ];
        int  left;
        int  slot;
        bit  refused;
        view    = spec_map;
        left    = free_count;
        slot    = free_head;
        refused = squash;
        for (int w = 0; w < `RN_WAYS; w++) begin
            exp_src1[w]  = view[src1_arch[w]];
            exp_src2[w]  = view[src2_arch[w]];
            exp_old[w]   = view[dest_arch[w]];
            exp_grant[w] = 1'b0;
            exp_dest[w]  = '0;
            if (rename_valid[w] && !refused) begin
                if (left > 0) begin
                    exp_grant[w] = 1'b1;
                    exp_dest[w]  = free_queue[slot];
                    slot         = (slot + 1) % `PHYS_REG_SZ;
                    left--;
                    view[dest_arch[w]] = exp_dest[w];
                end else begin
                    refused = 1'b1;
                end
            end
        end
    endfunction

    // state after the coming clock edge
    function automatic void advance_model();
        if (squash) begin
            spec_map   = commit_map;
            free_head  = commit_head;
            free_count = FREE_AT_RESET;
            pend_arch.delete();
            pend_prn.delete();
        end else begin
            for (int w = 0; w < `RN_WAYS; w++) begin
                if (exp_grant[w]) begin
                    spec_map[dest_arch[w]] = exp_dest[w];
                    free_head = (free_head + 1) % `PHYS_REG_SZ;
                    free_count--;
                    pend_arch.push_back(dest_arch[w]);
                    pend_prn.push_back(exp_dest[w]);
                end
            end
            for (int w = 0; w < `RN_WAYS; w++) begin
                if (retire_valid[w]) begin
                    free_queue[free_tail] = commit_map[retire_arch[w]];
                    free_tail = (free_tail + 1) % `PHYS_REG_SZ;
                    free_count++;
                    commit_map[retire_arch[w]] = retire_prn[w];
                    commit_head = (commit_head + 1) % `PHYS_REG_SZ;
                    void'(pend_arch.pop_front());
                    void'(pend_prn.pop_front());
                end
            end
        end
    endfunction

    function automatic void check_value(input string name, input logic [31:0] expected,
                                        input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h actual %h at time %0t",
                     name, expected, actual, $time);
            errors++;
        end
    endfunction

    // compare at the falling edge while the outputs are stable
    initial begin
        reset_model();
        forever begin
            @(negedge clock);
            if (reset) begin
                reset_model();
                check_value("rename_grant", 32'h0, 32'(rename_grant));
            end else begin
                compute_expected();
                check_value("rename_grant", 32'(exp_grant), 32'(rename_grant));
                check_value("dest_prn", 32'(exp_dest), 32'(dest_prn));
                check_value("old_prn", 32'(exp_old), 32'(old_prn));
                check_value("src1_prn", 32'(exp_src1), 32'(src1_prn));
                check_value("src2_prn", 32'(exp_src2), 32'(src2_prn));
                advance_model();
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    function automatic void set_idle();
        rename_valid = '0;
        dest_arch    = '0;
        src1_arch    = '0;
        src2_arch    = '0;
        squash       = 1'b0;
        retire_valid = '0;
        retire_arch  = '0;
        retire_prn   = '0;
    endfunction

    function automatic void set_way(input int w, input bit valid, input int dest,
                                    input int s1, input int s2);
        rename_valid[w] = valid;
        dest_arch[w]    = rename_pkg::arn_t'(dest);
        src1_arch[w]    = rename_pkg::arn_t'(s1);
        src2_arch[w]    = rename_pkg::arn_t'(s2);
    endfunction

    // retire up to n of the oldest pending renames
    function automatic void set_retire(input int n);
        int count;
        count = (n < pend_arch.size()) ? n : pend_arch.size();
        for (int w = 0; w < count; w++) begin
            retire_valid[w] = 1'b1;
            retire_arch[w]  = pend_arch[w];
            retire_prn[w]   = pend_prn[w];
        end
    endfunction

    task automatic next_drive_slot();
        @(posedge clock);
        #1;
        set_idle();
    endtask

    task automatic finish_test(input string name);
        @(negedge clock);
        #1;
        tests_done++;
        $display("test %0d %s: %0d failures", tests_done, name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic run_reset_lookups();
        for (int c = 0; c < 2; c++) begin
            next_drive_slot();
            for (int w = 0; w < `RN_WAYS; w++) begin
                set_way(w, 1'b0, 0, 4 * c + w, 4 * c + 2 + w);
            end
        end
        finish_test("reset lookups");
    endtask

    task automatic run_sequential_alloc();
        next_drive_slot();
        set_way(0, 1'b1, 0, 0, 1);
        set_way(1, 1'b1, 1, 0, 1);
        next_drive_slot();
        set_way(0, 1'b1, 0, 0, 1);
        set_way(1, 1'b1, 2, 1, 2);
        next_drive_slot();
        set_way(0, 1'b0, 0, 0, 1);
        set_way(1, 1'b0, 0, 2, 3);
        finish_test("sequential allocation");
    endtask

    task automatic run_group_forwarding();
        next_drive_slot();
        set_way(0, 1'b1, 5, 3, 4);
        set_way(1, 1'b1, 5, 5, 5);
        next_drive_slot();
        set_way(0, 1'b0, 0, 5, 5);
        finish_test("same-group forwarding");
    endtask

    task automatic run_exhaustion();
        // way 1 alone and then both ways until the queue runs dry
        for (int c = 0; c < 4; c++) begin
            next_drive_slot();
            for (int w = 0; w < `RN_WAYS; w++) begin
                set_way(w, (c > 0 || w == 1), (2 * c + w) % `ARCH_REG_SZ, w, c);
            end
        end
        // retires refill the queue in order
        for (int c = 0; c < 5; c++) begin
            next_drive_slot();
            for (int w = 0; w < `RN_WAYS; w++) begin
                set_way(w, 1'b1, (c + 3 * w) % `ARCH_REG_SZ, c, w);
            end
            set_retire(`RN_WAYS);
        end
        next_drive_slot();
        finish_test("exhaustion and back-pressure");
    endtask

    task automatic run_squash();
        for (int c = 0; c < 3; c++) begin
            next_drive_slot();
            for (int w = 0; w < `RN_WAYS; w++) begin
                set_way(w, 1'b1, (2 * c + w + 1) % `ARCH_REG_SZ, w, c);
            end
            if (c < 2) begin
                set_retire(1);
            end
        end
        next_drive_slot();
        set_way(0, 1'b1, 1, 0, 1);
        set_way(1, 1'b1, 2, 2, 3);
        squash = 1'b1;
        next_drive_slot();
        set_way(0, 1'b1, 6, 0, 1);
        set_way(1, 1'b0, 0, 2, 3);
        next_drive_slot();
        set_way(0, 1'b0, 0, 4, 5);
        set_way(1, 1'b0, 0, 6, 7);
        next_drive_slot();
        finish_test("squash recovery");
    endtask

    task automatic run_random_mix();
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            next_drive_slot();
            for (int w = 0; w < `RN_WAYS; w++) begin
                set_way(w, 1'($urandom_range(0, 1)), $urandom_range(0, `ARCH_REG_SZ - 1),
                        $urandom_range(0, `ARCH_REG_SZ - 1),
                        $urandom_range(0, `ARCH_REG_SZ - 1));
            end
            // occasional flush with retire held off
            if ($urandom_range(0, 31) == 0) begin
                squash = 1'b1;
            end else begin
                set_retire($urandom_range(0, `RN_WAYS));
            end
        end
        finish_test("random mix");
    endtask

    initial begin
        void'($urandom(SEED));
        set_idle();
        // requests during reset must see no grant
        rename_valid = '1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset        = 1'b0;
        rename_valid = '0;
        run_reset_lookups();
        run_sequential_alloc();
        run_group_forwarding();
        run_exhaustion();
        run_squash();
        run_random_mix();
        $display("tests %0d, checks %0d, failures %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
